/* compile.f */
+incdir+common
common/multTypesPkg.sv
common/axiLitePkg.sv
seqMult/baughWooleyCell.sv
seqMult/seqMultDatapath.sv
seqMult/seqMultSequencer.sv
verilog/multRegs.sv
verilog/multTop.sv
dv/multTop_properties.sv
dv/multTb.sv

/* Bender.yml */
package:
  name: mult_accel

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/multTypesPkg.sv
      - common/axiLitePkg.sv
      - seqMult/baughWooleyCell.sv
      - seqMult/seqMultDatapath.sv
      - seqMult/seqMultSequencer.sv
      - verilog/multRegs.sv
      - verilog/multTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/multTop_properties.sv
      - dv/multTb.sv

/* dv/multTb.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module multTb import multTypesPkg::*, axiLitePkg::*; ();

    localparam int DriveDly        = 1;
    localparam int NumJobs         = 153; // 50 + 50 + 40 + 1 + 12
    localparam int AccessPerJob    = 24;  // 3 writes, up to 20 polls, 1 result read
    localparam int PlannedAccesses = NumJobs * AccessPerJob + 16;
    localparam int TimeoutCycles   = 64 * PlannedAccesses;

    typedef struct packed {
        mulJob_t     job;
        logic [31:0] result;
    } jobRec_t;

    logic         clk;
    logic         rst_n;
    axiLiteReq_t  axiReq;
    axiLiteResp_t axiResp;

    logic [31:0] lcgState = 32'h15e8aab1;
    jobRec_t     jobQ[$];
    int          pushCount = 0;
    int          popCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrBase = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;

    multTop u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .axiReq  (axiReq),
        .axiResp (axiResp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ##################################################
    // helpers
    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [15:0] randOperand();
        logic [31:0] r;
        r = lcgNext();
        return r[31:16]; // upper half of the LCG state
    endfunction

    function automatic int stallCycles(input int stallMax);
        logic [31:0] r;
        if (stallMax == 0) return 0;
        r = lcgNext();
        return int'(r[31:16]) % (stallMax + 1);
    endfunction

    // N-bit operands, sign or zero extended, product cut to 2N bits
    function automatic logic [31:0] refProduct(input mulJob_t job);
        int          n;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] mask;
        case (job.size)
            SIZE4:   n = 4;
            SIZE8:   n = 8;
            default: n = 16;
        endcase
        mask = (32'd1 << n) - 32'd1;
        opA  = {16'h0, job.a} & mask;
        opB  = {16'h0, job.b} & mask;
        if (job.signedMode && opA[n-1]) opA = opA | ~mask;
        if (job.signedMode && opB[n-1]) opB = opB | ~mask;
        if (n == 16) return opA * opB;
        return (opA * opB) & ((32'd1 << (2 * n)) - 32'd1);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            $display("ERROR: %s got 0x%08h, expected 0x%08h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name);
        wait (popCount == pushCount);
        testsRun++;
        if (errorCount != testErrBase) begin
            testsFailed++;
            $display("test %0d %s: fail, %0d errors", testsRun, name,
                     errorCount - testErrBase);
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
        testErrBase = errorCount;
    endtask

    // ##################################################
    // AXI4-Lite master
    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            input int stall, output axiResp_e resp);
        @(posedge clk);
        #DriveDly;
        axiReq.awvalid = 1'b1;
        axiReq.awaddr  = addr;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = data;
        axiReq.wstrb   = 4'hF;
        @(negedge clk);
        while (!axiResp.awready) @(negedge clk);
        checkValue("wready", axiResp.wready, 1'b1); // rises with awready
        @(posedge clk);
        #DriveDly;
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #DriveDly;
        end
        axiReq.bready = 1'b1;
        @(negedge clk);
        while (!axiResp.bvalid) @(negedge clk);
        resp = axiResp.bresp;
        @(posedge clk);
        #DriveDly;
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, input int stall,
                           output logic [31:0] data, output axiResp_e resp);
        @(posedge clk);
        #DriveDly;
        axiReq.arvalid = 1'b1;
        axiReq.araddr  = addr;
        @(negedge clk);
        while (!axiResp.arready) @(negedge clk);
        @(posedge clk);
        #DriveDly;
        axiReq.arvalid = 1'b0;
        repeat (stall) begin
            @(posedge clk);
            #DriveDly;
        end
        axiReq.rready = 1'b1;
        @(negedge clk);
        while (!axiResp.rvalid) @(negedge clk);
        data = axiResp.rdata;
        resp = axiResp.rresp;
        @(posedge clk);
        #DriveDly;
        axiReq.rready = 1'b0;
    endtask

    // ##################################################
    // jobs
    task automatic startJob(input mulJob_t job, input int stallMax);
        axiResp_e resp;
        axiWrite(`REG_A, {16'h0, job.a}, stallCycles(stallMax), resp);
        checkValue("bresp A", resp, RESP_OKAY);
        axiWrite(`REG_B, {16'h0, job.b}, stallCycles(stallMax), resp);
        checkValue("bresp B", resp, RESP_OKAY);
        axiWrite(`REG_CTRL, {28'h0, job.signedMode, job.size, 1'b1},
                 stallCycles(stallMax), resp);
        checkValue("bresp CTRL", resp, RESP_OKAY);
    endtask

    task automatic waitJob(input mulJob_t job, input int stallMax);
        axiResp_e    resp;
        logic [31:0] status;
        logic [31:0] result;
        jobRec_t     rec;
        status = '0;
        while (!status[1]) begin // sticky done
            axiRead(`REG_STATUS, stallCycles(stallMax), status, resp);
            checkValue("rresp STATUS", resp, RESP_OKAY);
        end
        axiRead(`REG_RESULT, stallCycles(stallMax), result, resp);
        checkValue("rresp RESULT", resp, RESP_OKAY);
        rec.job    = job;
        rec.result = result;
        jobQ.push_back(rec);
        pushCount++;
    endtask

    task automatic randomJob(input opSize_e size, input logic signedMode,
                             input int stallMax, input logic [15:0] highBits);
        mulJob_t job;
        job.a          = randOperand() | highBits;
        job.b          = randOperand() | highBits;
        job.size       = size;
        job.signedMode = signedMode;
        startJob(job, stallMax);
        waitJob(job, stallMax);
    endtask

    // result compare against the reference
    initial begin : resultChecker
        jobRec_t rec;
        forever begin
            wait (pushCount != popCount);
            rec = jobQ.pop_front();
            checkValue($sformatf("RESULT a=%04h b=%04h size=%0d signed=%0b", rec.job.a,
                                 rec.job.b, rec.job.size, rec.job.signedMode),
                       rec.result, refProduct(rec.job));
            popCount++;
        end
    end

    // ##################################################
    // tests
    task automatic testReset();
        axiResp_e    resp;
        logic [31:0] data;
        checkValue("axiResp awready,wready,bvalid,arready,rvalid", {axiResp.awready,
                   axiResp.wready, axiResp.bvalid, axiResp.arready, axiResp.rvalid}, '0);
        checkValue("start,busy,done,digitValid", {u_dut.start, u_dut.busy, u_dut.done,
                   u_dut.digitValid}, '0);
        axiRead(`REG_STATUS, 0, data, resp);
        checkValue("rresp STATUS", resp, RESP_OKAY);
        checkValue("STATUS", data, '0);
        axiRead(`REG_RESULT, 0, data, resp);
        checkValue("rresp RESULT", resp, RESP_OKAY);
        checkValue("RESULT", data, '0);
        axiRead(`REG_CTRL, 0, data, resp);
        checkValue("rresp CTRL", resp, RESP_OKAY);
        checkValue("CTRL", data, '0);
        endTest("reset state");
    endtask

    task automatic testSignedExtremes();
        logic [15:0] extA[6] = '{16'h8000, 16'h8000, 16'hFFFF, 16'hFFFF, 16'h7FFF, 16'h8000};
        logic [15:0] extB[6] = '{16'h8000, 16'hFFFF, 16'h8000, 16'hFFFF, 16'h8000, 16'h7FFF};
        mulJob_t     job;
        for (int i = 0; i < 6; i++) begin
            job.a          = extA[i];
            job.b          = extB[i];
            job.size       = SIZE16;
            job.signedMode = 1'b1;
            startJob(job, 0);
            waitJob(job, 0);
        end
        for (int i = 0; i < 44; i++) randomJob(SIZE16, 1'b1, 0, 16'h0);
        endTest("signed 16-bit jobs");
    endtask

    task automatic testErrorsAndBusy();
        mulJob_t     job;
        axiResp_e    resp;
        logic [31:0] data;
        axiWrite(32'h14, 32'hDEAD_BEEF, 0, resp);
        checkValue("bresp 0x14", resp, RESP_SLVERR);
        axiRead(32'h14, 0, data, resp);
        checkValue("rresp 0x14", resp, RESP_SLVERR);
        checkValue("rdata 0x14", data, '0);
        job.a          = randOperand();
        job.b          = randOperand();
        job.size       = SIZE16;
        job.signedMode = 1'b1;
        startJob(job, 0);
        // a second job while the first runs gets dropped
        axiWrite(`REG_A, {16'h0, ~job.a}, 0, resp);
        checkValue("bresp A while busy", resp, RESP_OKAY);
        axiWrite(`REG_B, {16'h0, job.a ^ job.b}, 0, resp);
        checkValue("bresp B while busy", resp, RESP_OKAY);
        axiWrite(`REG_CTRL, 32'h3, 0, resp);
        checkValue("bresp CTRL while busy", resp, RESP_OKAY);
        axiRead(`REG_STATUS, 0, data, resp);
        checkValue("STATUS busy", data[0], 1'b1);
        waitJob(job, 0);
        axiRead(`REG_A, 0, data, resp);
        checkValue("A after busy write", data, {16'h0, job.a});
        endTest("SLVERR and writes while busy");
    endtask

    initial begin : mainSeq
        logic [31:0] r;
        axiReq = '0;
        rst_n  = 1'b0;
        repeat (10) @(posedge clk);
        #DriveDly;
        rst_n = 1'b1;

        testReset();
        for (int i = 0; i < 50; i++) randomJob(SIZE16, 1'b0, 0, 16'h0);
        endTest("unsigned 16-bit jobs");
        testSignedExtremes();
        for (int i = 0; i < 40; i++) begin
            randomJob((i % 2) ? SIZE8 : SIZE4, logic'((i / 2) % 2), 0, 16'h8000);
        end
        endTest("4 and 8-bit jobs with high garbage");
        testErrorsAndBusy();
        for (int i = 0; i < 12; i++) begin
            r = lcgNext();
            randomJob(opSize_e'(r[31:16] % 3), r[15], 5, 16'h0);
        end
        endTest("bready and rready stalls");

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* dv/multTop_properties.sv */
`timescale 1ns/1ps

module multTopProperties import axiLitePkg::*; (
    input logic         clk,
    input logic         rst_n,
    input axiLiteReq_t  axiReq,
    input axiLiteResp_t axiResp,
    input logic         busy,
    input logic         done,
    input logic         digitValid
);

    // ##################################################
    // response channels
    bHold: assert property (@(posedge clk) disable iff (!rst_n)
        axiResp.bvalid && !axiReq.bready |=> axiResp.bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (!rst_n)
        axiResp.rvalid && !axiReq.rready |=> axiResp.rvalid)
        else $error("rvalid dropped before rready");

    rDataStable: assert property (@(posedge clk) disable iff (!rst_n)
        axiResp.rvalid && !axiReq.rready |=> $stable(axiResp.rdata))
        else $error("rdata changed while stalled");

    // ##################################################
    // sequencer
    busyDoneExcl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else $error("busy and done high together");

    digitInJob: assert property (@(posedge clk) disable iff (!rst_n)
        digitValid |-> busy) // digits only inside a job
        else $error("digitValid outside a job");

endmodule

bind multTop multTopProperties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .axiReq     (axiReq),
    .axiResp    (axiResp),
    .busy       (busy),
    .done       (done),
    .digitValid (digitValid)
);

/* verilog/multTop.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module multTop import multTypesPkg::*, axiLitePkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  axiLiteReq_t  axiReq,
    output axiLiteResp_t axiResp
);

    mulJob_t               job;
    seqCtrl_t              ctrl;
    logic [4*`DIGIT_W-1:0] initSum;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic                  digitValid;
    logic [3:0]            digitIdx;
    digit_t                p;

    multRegs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .axiReq     (axiReq),
        .axiResp    (axiResp),
        .job        (job),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .digitValid (digitValid),
        .digitIdx   (digitIdx),
        .p          (p)
    );

    seqMultSequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .job        (job),
        .ctrl       (ctrl),
        .initSum    (initSum),
        .busy       (busy),
        .done       (done),
        .digitValid (digitValid),
        .digitIdx   (digitIdx)
    );

    // operands captured on start, job stays frozen while busy
    seqMultDatapath u_dp (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .a       (job.a),
        .b       (job.b),
        .ctrl    (ctrl),
        .initSum (initSum),
        .p       (p)
    );

endmodule

/* verilog/multRegs.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module multRegs import multTypesPkg::*, axiLitePkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  axiLiteReq_t  axiReq,
    output axiLiteResp_t axiResp,
    output mulJob_t      job,
    output logic         start,
    input  logic         busy,
    input  logic         done,
    input  logic         digitValid,
    input  logic [3:0]   digitIdx,
    input  digit_t       p
);

    logic                   wrAcc;
    logic                   rdAcc;
    logic                   bvalid;
    axiResp_e               bresp;
    logic                   rvalid;
    logic [`AXI_DATA_W-1:0] rdata;
    axiResp_e               rresp;
    logic [`AXI_DATA_W-1:0] rdMux;
    logic [`AXI_DATA_W-1:0] result;
    logic                   doneSticky;

    function automatic logic isMapped(input logic [`AXI_ADDR_W-1:0] addr);
        return (addr == `REG_A) || (addr == `REG_B) || (addr == `REG_CTRL)
            || (addr == `REG_STATUS) || (addr == `REG_RESULT);
    endfunction

    function automatic logic [`MAX_W-1:0] mergeBytes(
        input logic [`MAX_W-1:0]   old,
        input logic [`MAX_W-1:0]   data,
        input logic [`MAX_W/8-1:0] strb
    );
        logic [`MAX_W-1:0] merged;
        merged = old;
        for (int i = 0; i < `MAX_W/8; i++) begin
            if (strb[i]) merged[8*i +: 8] = data[8*i +: 8];
        end
        return merged;
    endfunction

    // ##################################################
    // write channel
    assign wrAcc = axiReq.awvalid & axiReq.wvalid & ~bvalid; // one B outstanding

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wrAcc) begin
            bvalid <= 1'b1;
            bresp  <= isMapped(axiReq.awaddr) ? RESP_OKAY : RESP_SLVERR;
        end else if (axiReq.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wrAcc && !busy) begin // config frozen while a job runs
                case (axiReq.awaddr)
                    `REG_A: job.a <= mergeBytes(job.a, axiReq.wdata[`MAX_W-1:0],
                                                axiReq.wstrb[`MAX_W/8-1:0]);
                    `REG_B: job.b <= mergeBytes(job.b, axiReq.wdata[`MAX_W-1:0],
                                                axiReq.wstrb[`MAX_W/8-1:0]);
                    `REG_CTRL: begin
                        if (axiReq.wstrb[0]) begin
                            job.size       <= opSize_e'(axiReq.wdata[2:1]);
                            job.signedMode <= axiReq.wdata[3];
                            start          <= axiReq.wdata[0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ##################################################
    // result collection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doneSticky <= 1'b0;
            result     <= '0;
        end else if (start) begin
            doneSticky <= 1'b0;
            result     <= '0;
        end else begin
            if (done) doneSticky <= 1'b1;
            if (digitValid) result[digitIdx*`DIGIT_W +: `DIGIT_W] <= p;
        end
    end

    // ##################################################
    // read channel
    assign rdAcc = axiReq.arvalid & ~rvalid;

    always_comb begin
        case (axiReq.araddr)
            `REG_A:      rdMux = `AXI_DATA_W'(job.a);
            `REG_B:      rdMux = `AXI_DATA_W'(job.b);
            `REG_CTRL:   rdMux = `AXI_DATA_W'({job.signedMode, job.size, 1'b0});
            `REG_STATUS: rdMux = `AXI_DATA_W'({doneSticky, busy});
            `REG_RESULT: rdMux = result;
            default:     rdMux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= RESP_OKAY;
        end else if (rdAcc) begin
            rvalid <= 1'b1;
            rresp  <= isMapped(axiReq.araddr) ? RESP_OKAY : RESP_SLVERR;
        end else if (axiReq.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAcc) rdata <= rdMux; // held while rready is low
    end

    always_comb begin
        axiResp         = '0;
        axiResp.awready = wrAcc;
        axiResp.wready  = wrAcc;
        axiResp.bvalid  = bvalid;
        axiResp.bresp   = bresp;
        axiResp.arready = rdAcc;
        axiResp.rvalid  = rvalid;
        axiResp.rdata   = rdata;
        axiResp.rresp   = rresp;
    end

endmodule

/* seqMult/seqMultSequencer.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module seqMultSequencer import multTypesPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  mulJob_t               job,
    output seqCtrl_t              ctrl,
    output logic [4*`DIGIT_W-1:0] initSum,
    output logic                  busy,
    output logic                  done,
    output logic                  digitValid,
    output logic [3:0]            digitIdx
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        LAST
    } seqState_e;

    seqState_e  state;
    logic [3:0] col;      // output column k
    logic [2:0] pairA;    // multiplier digit i, multiplicand digit is k - i
    logic [2:0] selB;
    logic [2:0] topDig;   // D - 1
    logic [3:0] lastCol;  // 2D - 1
    logic [2:0] pairHi;
    logic [4:0] colPlus4;
    logic       colEnd;
    logic       tailCol;

    // first multiplier digit of column k
    function automatic logic [2:0] firstPair(input logic [3:0] k, input logic [2:0] top);
        logic [3:0] diff;
        diff = k - {1'b0, top};
        return (k > {1'b0, top}) ? diff[2:0] : 3'd0;
    endfunction

    always_comb begin
        case (job.size)
            SIZE4:   topDig = 3'd1;
            SIZE8:   topDig = 3'd3;
            default: topDig = 3'd7;
        endcase
    end

    assign lastCol  = {topDig, 1'b1};
    assign pairHi   = (col > {1'b0, topDig}) ? topDig : col[2:0];
    assign selB     = col[2:0] - pairA;
    assign colEnd   = (pairA == pairHi);
    assign tailCol  = (col == lastCol);
    assign colPlus4 = {1'b0, col} + 5'd4;

    // 2^N + 2^(2N-1) correction, fits the preload only for 4-bit operands
    assign initSum = (job.signedMode && topDig == 3'd1) ? 8'h90 : 8'h00;

    // ##################################################
    // column walk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            col   <= '0;
            pairA <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        col   <= '0;
                        pairA <= '0;
                    end
                end
                RUN: begin
                    if (tailCol) begin
                        state <= LAST;
                    end else if (colEnd) begin
                        col   <= col + 4'd1;
                        pairA <= firstPair(col + 4'd1, topDig);
                    end else begin
                        pairA <= pairA + 3'd1;
                    end
                end
                default: state <= IDLE; // last digit on p
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        if (state == RUN) begin
            ctrl.muxSelA = pairA;
            ctrl.muxSelB = selB;
            ctrl.lastOut = tailCol;
            if (!tailCol) begin
                ctrl.invertFirstBit  = job.signedMode & (pairA == topDig);
                ctrl.invertSecondRow = job.signedMode & (selB == topDig);
                ctrl.countLast2      = colEnd;
                // correction bits beyond the preload enter four digits early
                ctrl.countShiftInput[0] = job.signedMode & colEnd
                                        & (colPlus4 == {2'b00, topDig} + 5'd1);
                ctrl.countShiftInput[1] = job.signedMode & colEnd
                                        & (colPlus4 == {1'b0, lastCol});
            end
        end
    end

    // ##################################################
    // status toward the register block
    assign busy = (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digitValid <= 1'b0;
            digitIdx   <= '0;
            done       <= 1'b0;
        end else begin
            digitValid <= ctrl.countLast2 | ctrl.lastOut; // p loads on the same edge
            digitIdx   <= col;
            done       <= (state == LAST);
        end
    end

endmodule

/* seqMult/seqMultDatapath.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module seqMultDatapath import multTypesPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [`MAX_W-1:0]     a,
    input  logic [`MAX_W-1:0]     b,
    input  seqCtrl_t              ctrl,
    input  logic [4*`DIGIT_W-1:0] initSum,
    output digit_t                p
);

    localparam int AccW = 2 * `DIGIT_W;

    logic [`MAX_W-1:0] regA;
    logic [`MAX_W-1:0] regB;
    digit_t            digA;
    digit_t            digB;
    logic [AccW-1:0]   prod;
    logic [AccW-1:0]   accumSum;
    logic [AccW-1:0]   carryCount;
    logic [AccW:0]     sumWide;
    logic [AccW-1:0]   nextAccum;
    logic [AccW-1:0]   nextCarry;
    logic              shiftCol;

    // ##################################################
    // operand digits
    always_ff @(posedge clk) begin
        if (start) begin
            regA <= a;
            regB <= b;
        end
    end

    assign digA = regA[ctrl.muxSelA*`DIGIT_W +: `DIGIT_W];
    assign digB = regB[ctrl.muxSelB*`DIGIT_W +: `DIGIT_W];

    baughWooleyCell u_cell (
        .multiplier      (digA),
        .multiplicand    (digB),
        .invertFirstBit  (ctrl.invertFirstBit),
        .invertSecondRow (ctrl.invertSecondRow),
        .product         (prod)
    );

    // ##################################################
    // column accumulator
    assign sumWide   = ctrl.lastOut ? {1'b0, accumSum}
                                    : {1'b0, accumSum} + {1'b0, prod};
    assign nextAccum = sumWide[AccW-1:0];
    assign nextCarry = carryCount + AccW'(sumWide[AccW]); // count adder carry-outs
    assign shiftCol  = ctrl.countLast2 | ctrl.lastOut;

    // column value is accumSum + carryCount * 2^AccW
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accumSum   <= '0;
            carryCount <= '0;
        end else if (start) begin
            accumSum   <= initSum[AccW-1:0];
            carryCount <= initSum[2*AccW-1:AccW];
        end else if (shiftCol) begin
            // drop one digit, carries move down into the accumulator
            accumSum   <= {nextCarry[`DIGIT_W-1:0], nextAccum[AccW-1:`DIGIT_W]};
            carryCount <= {ctrl.countShiftInput, nextCarry[AccW-1:`DIGIT_W]};
        end else begin
            accumSum   <= nextAccum;
            carryCount <= nextCarry;
        end
    end

    // finished digit of the closing column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p <= '0;
        end else if (start) begin
            p <= '0;
        end else if (shiftCol) begin
            p <= nextAccum[`DIGIT_W-1:0];
        end
    end

endmodule

/* seqMult/baughWooleyCell.sv */
`timescale 1ns/1ps
`include "mult_defs.svh"

module baughWooleyCell import multTypesPkg::*; (
    input  digit_t                multiplier,
    input  digit_t                multiplicand,
    input  logic                  invertFirstBit,
    input  logic                  invertSecondRow,
    output logic [2*`DIGIT_W-1:0] product
);

    logic pp00;
    logic pp10;
    logic pp01;
    logic pp11;

    // row 0 takes multiplicand bit 0, row 1 takes bit 1
    assign pp00 = multiplier[0] & multiplicand[0];
    assign pp10 = (multiplier[1] & multiplicand[0]) ^ invertFirstBit;
    assign pp01 = (multiplier[0] & multiplicand[1]) ^ invertSecondRow;
    // sign times sign stays positive when both flags are set
    assign pp11 = (multiplier[1] & multiplicand[1]) ^ invertFirstBit ^ invertSecondRow;

    assign product = {3'b000, pp00}
                   + {2'b00, pp10, 1'b0}
                   + {2'b00, pp01, 1'b0}
                   + {1'b0, pp11, 2'b00};

endmodule

/* common/axiLitePkg.sv */
`include "mult_defs.svh"

package axiLitePkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axiResp_e;

    // master side
    typedef struct packed {
        logic                      awvalid;
        logic [`AXI_ADDR_W-1:0]    awaddr;
        logic                      wvalid;
        logic [`AXI_DATA_W-1:0]    wdata;
        logic [`AXI_DATA_W/8-1:0]  wstrb;
        logic                      bready;
        logic                      arvalid;
        logic [`AXI_ADDR_W-1:0]    araddr;
        logic                      rready;
    } axiLiteReq_t;

    // slave side
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        axiResp_e               bresp;
        logic                   arready;
        logic                   rvalid;
        logic [`AXI_DATA_W-1:0] rdata;
        axiResp_e               rresp;
    } axiLiteResp_t;

endpackage

/* common/multTypesPkg.sv */
`include "mult_defs.svh"

package multTypesPkg;

    // one product or operand digit
    typedef logic [`DIGIT_W-1:0] digit_t;

    typedef enum logic [1:0] {
        SIZE4  = 2'd0,
        SIZE8  = 2'd1,
        SIZE16 = 2'd2
    } opSize_e;

    // job as configured by software
    typedef struct packed {
        logic [`MAX_W-1:0] a;
        logic [`MAX_W-1:0] b;
        opSize_e           size;
        logic              signedMode;
    } mulJob_t;

    // per-cycle datapath control
    typedef struct packed {
        logic [2:0] muxSelA;
        logic [2:0] muxSelB;
        logic       invertFirstBit;  // multiplier digit holds the sign bit
        logic       invertSecondRow; // multiplicand digit holds the sign bit
        logic       countLast2;      // last pair of a column
        logic       lastOut;         // flush column, adder idle
        logic [1:0] countShiftInput;
    } seqCtrl_t;

endpackage

/* common/mult_defs.svh */
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// digit-serial multiplier geometry
`define DIGIT_W 2
`define MAX_W   16

// AXI4-Lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// register map, byte offsets
`define REG_A      32'h0000_0000
`define REG_B      32'h0000_0004
`define REG_CTRL   32'h0000_0008 // start, size, signed
`define REG_STATUS 32'h0000_000C // busy, done
`define REG_RESULT 32'h0000_0010

`endif
